/* Makefile */
# Verilator build and run of the CSR unit testbench

TOP := csrUnitTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log for failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir -o csrUnitSim
	-./obj_dir/csrUnitSim > sim.log 2>&1
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
+incdir+tb
hdl/csrPkg.sv
hdl/csrDecode.sv
hdl/csrMachine.sv
hdl/csrExecute.sv
hdl/csrResult.sv
hdl/csrUnit.sv
tb/csrUnitTb.sv

/* hdl/csrDecode.sv */
// SYSTEM instruction decoder
`timescale 1ns/100ps

module csrDecode (
  input  logic           valid,
  input  logic [31:0]    instr,
  input  logic [31:0]    rs1Val,
  input  logic [31:0]    pc,
  output csrPkg::csrReqT req
);
  import csrPkg::*;

  logic [2:0] funct3;
  logic [4:0] rs1Field;
  logic       isSystem;

  assign funct3   = instr[14:12];
  assign rs1Field = instr[19:15];
  assign isSystem = (instr[6:0] == sysOpcode);

  always_comb begin
    req       = '0;
    req.valid = valid;
    req.adr   = instr[31:20];
    req.rd    = instr[11:7];
    req.pc    = pc;
    req.instr = instr;
    req.op    = opNone;
    if (valid) begin
      req.op = opIllegal;
      if (isSystem) begin
        case (funct3)
          // Privileged forms must match the whole word
          3'b000: begin
            if (instr == ecallWord) begin
              req.op = opEcall;
            end else if (instr == ebreakWord) begin
              req.op = opEbreak;
            end else if (instr == mretWord) begin
              req.op = opMret;
            end
          end
          3'b001, 3'b101: begin
            req.op     = opRw;
            req.writes = 1'b1;
          end
          3'b010, 3'b110: begin
            req.op     = opRs;
            req.writes = (rs1Field != 5'd0);
          end
          3'b011, 3'b111: begin
            req.op     = opRc;
            req.writes = (rs1Field != 5'd0);
          end
          default: begin
            req.op = opIllegal;
          end
        endcase
        // Immediate forms use the rs1 field as a zero-extended uimm
        req.operand = funct3[2] ? {27'b0, rs1Field} : rs1Val;
      end
    end
  end

endmodule

/* hdl/csrExecute.sv */
// CSR operation and trap control
`timescale 1ns/100ps

module csrExecute (
  input  csrPkg::csrReqT     req,
  input  logic [31:0]        readVal,
  input  logic               illegal,
  input  logic               irqTake,
  input  csrPkg::mtvecU      mtvec,
  input  logic [31:0]        mepc,
  output csrPkg::csrWriteT   wr,
  output csrPkg::csrResultT  next
);
  import csrPkg::*;

  logic        isCsr;
  logic [31:0] trapBase;
  logic [31:0] irqTarget;

  assign isCsr    = req.op inside {opRw, opRs, opRc};
  assign trapBase = {mtvec.f.base, 2'b00};

  // Vectored mode jumps to base plus four times the cause
  assign irqTarget = (mtvec.f.mode == 2'b01) ? trapBase + (causeExtIrq << 2) : trapBase;

  always_comb begin
    wr         = '0;
    next       = '0;
    wr.adr     = req.adr;
    wr.epc     = req.pc;
    next.valid = req.valid;
    next.rd    = req.rd;
    if (req.valid) begin
      if (irqTake) begin
        wr.trap         = 1'b1;
        wr.cause        = {1'b1, causeExtIrq[30:0]};
        next.redirect   = 1'b1;
        next.targetPc   = irqTarget;
      end else if (req.op inside {opIllegal, opEcall, opEbreak} || (isCsr && illegal)) begin
        wr.trap         = 1'b1;
        next.redirect   = 1'b1;
        next.targetPc   = trapBase;
        case (req.op)
          opEcall:  wr.cause = causeEcallM;
          opEbreak: wr.cause = causeBreak;
          default: begin
            wr.cause = causeIllegal;
            wr.tval  = req.instr;
          end
        endcase
      end else if (req.op == opMret) begin
        wr.mret         = 1'b1;
        next.redirect   = 1'b1;
        next.targetPc   = mepc;
      end else if (isCsr) begin
        // Old value goes to rd, new value to the CSR
        next.rdWe  = 1'b1;
        next.rdVal = readVal;
        wr.we      = req.writes;
        case (req.op)
          opRs:    wr.data = readVal | req.operand;
          opRc:    wr.data = readVal & ~req.operand;
          default: wr.data = req.operand;
        endcase
      end
    end
  end

endmodule

/* hdl/csrMachine.sv */
// Machine-mode CSR registers
`timescale 1ns/100ps

module csrMachine (
  input  logic              clk,
  input  logic              rstN,
  input  csrPkg::csrReqT    req,
  input  csrPkg::csrWriteT  wr,
  input  logic              irqExt,
  output logic [31:0]       readVal,
  output logic              illegal,
  output csrPkg::mtvecU     mtvec,
  output logic [31:0]       mepc,
  output csrPkg::mstatusT   mstatus,
  output logic              irqTake,
  output logic [31:0]       pmpCfg0,
  output logic [3:0][31:0]  pmpAddr
);
  import csrPkg::*;

  logic [31:0] mieReg;
  logic [31:0] mscratch;
  logic [31:0] mcause;
  logic [31:0] mtval;
  logic [31:0] mip;
  logic [31:0] mstatusWord;

  logic       weMstatus;
  logic       weMtvec;
  logic       weMie;
  logic       weMscratch;
  logic       weMepc;
  logic       weMcause;
  logic       weMtval;
  logic       wePmpCfg;
  logic [3:0] wePmpAddr;

  logic unknownAdr;
  logic readOnly;

  //////////////////////////////////////////////////////////////////////
  // Write enables
  //////////////////////////////////////////////////////////////////////
  assign weMstatus  = wr.we && (wr.adr == mstatusAdr);
  assign weMtvec    = wr.we && (wr.adr == mtvecAdr);
  assign weMie      = wr.we && (wr.adr == mieAdr);
  assign weMscratch = wr.we && (wr.adr == mscratchAdr);
  assign weMepc     = wr.we && (wr.adr == mepcAdr);
  assign weMcause   = wr.we && (wr.adr == mcauseAdr);
  assign weMtval    = wr.we && (wr.adr == mtvalAdr);
  assign wePmpCfg   = wr.we && (wr.adr == pmpcfg0Adr);

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wePmpAddr[i] = wr.we && (wr.adr == pmpaddr0Adr + 12'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mstatus <= '0;
    end else if (wr.trap) begin
      mstatus.mpie <= mstatus.mie;
      mstatus.mie  <= 1'b0;
    end else if (wr.mret) begin
      mstatus.mie  <= mstatus.mpie;
      mstatus.mpie <= 1'b1;
    end else if (weMstatus) begin
      mstatus.mie  <= wr.data[3];
      mstatus.mpie <= wr.data[7];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mtvec    <= '0;
      mieReg   <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      pmpCfg0  <= '0;
      pmpAddr  <= '0;
    end else begin
      // Bit 1 of mtvec reads as zero, leaving modes 0 and 1
      if (weMtvec) begin
        mtvec.raw <= {wr.data[31:2], 1'b0, wr.data[0]};
      end
      if (weMie) begin
        mieReg <= wr.data & mieMask;
      end
      if (weMscratch) begin
        mscratch <= wr.data;
      end
      // Trap state wins over a CSR write to the same register
      if (wr.trap) begin
        mepc   <= wr.epc;
        mcause <= wr.cause;
        mtval  <= wr.tval;
      end else begin
        if (weMepc) begin
          mepc <= wr.data;
        end
        if (weMcause) begin
          mcause <= wr.data;
        end
        if (weMtval) begin
          mtval <= wr.data;
        end
      end
      if (wePmpCfg) begin
        pmpCfg0 <= wr.data;
      end
      for (int i = 0; i < 4; i++) begin
        if (wePmpAddr[i]) begin
          pmpAddr[i] <= wr.data;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////
  assign mip         = {20'b0, irqExt, 11'b0};
  assign mstatusWord = {24'b0, mstatus.mpie, 3'b0, mstatus.mie, 3'b0};

  always_comb begin
    unknownAdr = 1'b0;
    case (req.adr)
      misaAdr:      readVal = misaValue;
      mvendoridAdr: readVal = '0;
      marchidAdr:   readVal = '0;
      mimpidAdr:    readVal = mimpidValue;
      mhartidAdr:   readVal = '0;
      mstatusAdr:   readVal = mstatusWord;
      mtvecAdr:     readVal = mtvec.raw;
      mieAdr:       readVal = mieReg;
      mipAdr:       readVal = mip;
      mscratchAdr:  readVal = mscratch;
      mepcAdr:      readVal = mepc;
      mcauseAdr:    readVal = mcause;
      mtvalAdr:     readVal = mtval;
      pmpcfg0Adr:   readVal = pmpCfg0;
      12'h3B0:      readVal = pmpAddr[0];
      12'h3B1:      readVal = pmpAddr[1];
      12'h3B2:      readVal = pmpAddr[2];
      12'h3B3:      readVal = pmpAddr[3];
      default: begin
        readVal    = '0;
        unknownAdr = 1'b1;
      end
    endcase
  end

  // ID registers reject writes, other read-only bits ignore them
  assign readOnly = req.adr inside {mvendoridAdr, marchidAdr, mimpidAdr, mhartidAdr};
  assign illegal  = unknownAdr || (req.writes && readOnly);

  // External interrupt enable sits in mie bit 11
  assign irqTake = req.valid && mstatus.mie && mieReg[11] && irqExt;

  trapMretExclusive: assert property (
    @(posedge clk) disable iff (!rstN) !(wr.trap && wr.mret)
  ) else $error("trap and mret requested together");

endmodule

/* hdl/csrPkg.sv */
// Machine CSR definitions
package csrPkg;

  localparam int xlen = 32;

  //////////////////////////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////////////////////////
  localparam logic [11:0] mvendoridAdr = 12'hF11;
  localparam logic [11:0] marchidAdr   = 12'hF12;
  localparam logic [11:0] mimpidAdr    = 12'hF13;
  localparam logic [11:0] mhartidAdr   = 12'hF14;
  localparam logic [11:0] mstatusAdr   = 12'h300;
  localparam logic [11:0] misaAdr      = 12'h301;
  localparam logic [11:0] mieAdr       = 12'h304;
  localparam logic [11:0] mtvecAdr     = 12'h305;
  localparam logic [11:0] mscratchAdr  = 12'h340;
  localparam logic [11:0] mepcAdr      = 12'h341;
  localparam logic [11:0] mcauseAdr    = 12'h342;
  localparam logic [11:0] mtvalAdr     = 12'h343;
  localparam logic [11:0] mipAdr       = 12'h344;
  localparam logic [11:0] pmpcfg0Adr   = 12'h3A0;
  localparam logic [11:0] pmpaddr0Adr  = 12'h3B0;

  // SYSTEM opcode and the fixed privileged encodings
  localparam logic [6:0]  sysOpcode  = 7'b1110011;
  localparam logic [31:0] ecallWord  = 32'h0000_0073;
  localparam logic [31:0] ebreakWord = 32'h0010_0073;
  localparam logic [31:0] mretWord   = 32'h3020_0073;

  // Exception and interrupt codes
  localparam logic [xlen-1:0] causeIllegal = 32'd2;
  localparam logic [xlen-1:0] causeBreak   = 32'd3;
  localparam logic [xlen-1:0] causeEcallM  = 32'd11;
  localparam logic [xlen-1:0] causeExtIrq  = 32'd11;

  // Hardwired IDs, MXL of 1 with only the I extension
  localparam logic [xlen-1:0] misaValue   = 32'h4000_0100;
  localparam logic [xlen-1:0] mimpidValue = 32'h0000_0100;

  // MSIE, MTIE and MEIE are the only writable mie bits
  localparam logic [xlen-1:0] mieMask = 32'h0000_0888;

  typedef enum logic [2:0] {
    opNone, opRw, opRs, opRc, opEcall, opEbreak, opMret, opIllegal
  } csrOpE;

  //////////////////////////////////////////////////////////////////////
  // Structs passed between the stages
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic            valid;
    csrOpE           op;
    logic [11:0]     adr;
    logic [4:0]      rd;
    logic            writes;
    logic [xlen-1:0] operand;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;   // raw word, becomes mtval on illegal
  } csrReqT;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvecFieldT;

  // Trap vector seen either as the stored word or as base and mode
  typedef union packed {
    logic [xlen-1:0] raw;
    mtvecFieldT      f;
  } mtvecU;

  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatusT;

  typedef struct packed {
    logic            we;
    logic [11:0]     adr;
    logic [xlen-1:0] data;
    logic            trap;
    logic            mret;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] cause;
    logic [xlen-1:0] tval;
  } csrWriteT;

  typedef struct packed {
    logic            valid;
    logic            rdWe;
    logic [4:0]      rd;
    logic [xlen-1:0] rdVal;
    logic            redirect;
    logic [xlen-1:0] targetPc;
  } csrResultT;

endpackage

/* hdl/csrResult.sv */
// Writeback result register
`timescale 1ns/100ps

module csrResult (
  input  logic               clk,
  input  logic               rstN,
  input  csrPkg::csrResultT  next,
  output csrPkg::csrResultT  result
);
  import csrPkg::*;

  csrResultT resultQ;

  //////////////////////////////////////////////////////////////////////
  // One cycle of latency between strobe and result
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultQ <= '0;
    end else begin
      resultQ <= next;
    end
  end

  assign result = resultQ;

  // A redirected instruction never also writes a register
  redirectNoWrite: assert property (
    @(posedge clk) disable iff (!rstN) resultQ.redirect |-> !resultQ.rdWe
  ) else $error("redirect together with rdWe");

  // Writes only come from a valid slot
  writeNeedsValid: assert property (
    @(posedge clk) disable iff (!rstN) resultQ.rdWe |-> resultQ.valid
  ) else $error("rdWe without valid");

endmodule

/* hdl/csrUnit.sv */
// Machine CSR unit top level
`timescale 1ns/100ps

module csrUnit (
  input  logic               clk,
  input  logic               rstN,
  input  logic               valid,
  input  logic [31:0]        instr,
  input  logic [31:0]        rs1Val,
  input  logic [31:0]        pc,
  input  logic               irqExt,
  output csrPkg::csrResultT  result,
  output logic [31:0]        pmpCfg0,
  output logic [3:0][31:0]   pmpAddr
);
  import csrPkg::*;

  csrReqT    req;
  csrWriteT  wr;
  csrResultT next;
  mtvecU     mtvec;

  logic [31:0] readVal;
  logic [31:0] mepc;
  logic        illegal;
  logic        irqTake;

  csrDecode i_csrDecode (
    .valid  (valid),
    .instr  (instr),
    .rs1Val (rs1Val),
    .pc     (pc),
    .req    (req)
  );

  csrMachine i_csrMachine (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .wr      (wr),
    .irqExt  (irqExt),
    .readVal (readVal),
    .illegal (illegal),
    .mtvec   (mtvec),
    .mepc    (mepc),
    .mstatus (),
    .irqTake (irqTake),
    .pmpCfg0 (pmpCfg0),
    .pmpAddr (pmpAddr)
  );

  csrExecute i_csrExecute (
    .req     (req),
    .readVal (readVal),
    .illegal (illegal),
    .irqTake (irqTake),
    .mtvec   (mtvec),
    .mepc    (mepc),
    .wr      (wr),
    .next    (next)
  );

  csrResult i_csrResult (
    .clk    (clk),
    .rstN   (rstN),
    .next   (next),
    .result (result)
  );

endmodule

/* tb/csrModel.svh */
// CSR reference model

logic             mieBit;
logic             mpieBit;
logic [31:0]      mtvecReg;
logic [31:0]      mieReg;
logic [31:0]      mscratchReg;
logic [31:0]      mepcReg;
logic [31:0]      mcauseReg;
logic [31:0]      mtvalReg;
logic [31:0]      pmpCfgReg;
logic [3:0][31:0] pmpAddrReg;

task automatic resetModel();
  mieBit      = 1'b0;
  mpieBit     = 1'b0;
  mtvecReg    = '0;
  mieReg      = '0;
  mscratchReg = '0;
  mepcReg     = '0;
  mcauseReg   = '0;
  mtvalReg    = '0;
  pmpCfgReg   = '0;
  pmpAddrReg  = '0;
endtask

// Returns 1 for an implemented address
function automatic logic readCsr(input logic [11:0] adr, input logic irq,
                                 output logic [31:0] val);
  readCsr = 1'b1;
  case (adr)
    12'h301: val = 32'h4000_0100;
    12'hF11, 12'hF12, 12'hF14: val = '0;
    12'hF13: val = 32'h0000_0100;
    12'h300: val = {24'b0, mpieBit, 3'b0, mieBit, 3'b0};
    12'h305: val = mtvecReg;
    12'h304: val = mieReg;
    12'h344: val = {20'b0, irq, 11'b0};
    12'h340: val = mscratchReg;
    12'h341: val = mepcReg;
    12'h342: val = mcauseReg;
    12'h343: val = mtvalReg;
    12'h3A0: val = pmpCfgReg;
    12'h3B0: val = pmpAddrReg[0];
    12'h3B1: val = pmpAddrReg[1];
    12'h3B2: val = pmpAddrReg[2];
    12'h3B3: val = pmpAddrReg[3];
    default: begin
      val     = '0;
      readCsr = 1'b0;
    end
  endcase
endfunction

// WARL rules applied on store, read-only registers ignore writes
task automatic writeCsr(input logic [11:0] adr, input logic [31:0] data);
  case (adr)
    12'h300: begin
      mieBit  = data[3];
      mpieBit = data[7];
    end
    12'h305: mtvecReg    = data & 32'hFFFF_FFFD;
    12'h304: mieReg      = data & 32'h0000_0888;
    12'h340: mscratchReg = data;
    12'h341: mepcReg     = data;
    12'h342: mcauseReg   = data;
    12'h343: mtvalReg    = data;
    12'h3A0: pmpCfgReg   = data;
    12'h3B0: pmpAddrReg[0] = data;
    12'h3B1: pmpAddrReg[1] = data;
    12'h3B2: pmpAddrReg[2] = data;
    12'h3B3: pmpAddrReg[3] = data;
    default: begin
    end
  endcase
endtask

task automatic enterTrap(input logic [31:0] epc, input logic [31:0] cause,
                         input logic [31:0] tval);
  mepcReg   = epc;
  mcauseReg = cause;
  mtvalReg  = tval;
  mpieBit   = mieBit;
  mieBit    = 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// One strobe in, expected result out, state advanced
//////////////////////////////////////////////////////////////////////
task automatic predictStep(input logic v, input logic [31:0] ins, input logic [31:0] r1,
                           input logic [31:0] p, input logic irq, output csrResultT exp);
  logic [2:0]  f3;
  logic [4:0]  rs1f;
  logic [11:0] adr;
  logic [31:0] oldVal;
  logic [31:0] operand;
  logic [31:0] newVal;
  logic [31:0] base;
  logic        known;
  logic        isCsr;
  logic        doWrite;
  logic        bad;
  exp = '0;
  if (v) begin
    f3      = ins[14:12];
    rs1f    = ins[19:15];
    adr     = ins[31:20];
    base    = {mtvecReg[31:2], 2'b00};
    known   = readCsr(adr, irq, oldVal);
    isCsr   = (ins[6:0] == 7'h73) && (f3[1:0] != 2'b00);
    doWrite = (f3[1:0] == 2'b01) || (rs1f != 5'd0);
    bad     = isCsr && (!known || (doWrite && adr >= 12'hF11 && adr <= 12'hF14));
    exp.valid = 1'b1;
    exp.rd    = ins[11:7];
    if (mieBit && mieReg[11] && irq) begin
      exp.redirect = 1'b1;
      exp.targetPc = (mtvecReg[1:0] == 2'b01) ? base + 32'd44 : base;
      enterTrap(p, 32'h8000_000B, 32'd0);
    end else if (ins == 32'h0000_0073) begin
      exp.redirect = 1'b1;
      exp.targetPc = base;
      enterTrap(p, 32'd11, 32'd0);
    end else if (ins == 32'h0010_0073) begin
      exp.redirect = 1'b1;
      exp.targetPc = base;
      enterTrap(p, 32'd3, 32'd0);
    end else if (ins == 32'h3020_0073) begin
      exp.redirect = 1'b1;
      exp.targetPc = mepcReg;
      mieBit       = mpieBit;
      mpieBit      = 1'b1;
    end else if (!isCsr || bad) begin
      exp.redirect = 1'b1;
      exp.targetPc = base;
      enterTrap(p, 32'd2, ins);
    end else begin
      operand = f3[2] ? {27'b0, rs1f} : r1;
      case (f3[1:0])
        2'b10:   newVal = oldVal | operand;
        2'b11:   newVal = oldVal & ~operand;
        default: newVal = operand;
      endcase
      exp.rdWe  = 1'b1;
      exp.rdVal = oldVal;
      if (doWrite) begin
        writeCsr(adr, newVal);
      end
    end
  end
endtask

/* tb/csrUnitTb.sv */
// CSR unit testbench
`timescale 1ns/100ps

module csrUnitTb;
  import csrPkg::*;

  localparam int numSweep   = 19;
  localparam int numRandom  = 600;
  localparam int numStim    = numSweep + numRandom;
  localparam int cycleLimit = 2 * numStim + 50;

  logic             clk;
  logic             rstN;
  logic             valid;
  logic [31:0]      instr;
  logic [31:0]      rs1Val;
  logic [31:0]      pc;
  logic             irqExt;
  csrResultT        result;
  logic [31:0]      pmpCfg0;
  logic [3:0][31:0] pmpAddr;

  csrResultT expResult;
  integer    seed = 32'hac05;
  int        cycleCount = 0;

  logic [11:0] adrTable [numSweep] = '{
    12'h301, 12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'h300, 12'h305,
    12'h304, 12'h344, 12'h340, 12'h341, 12'h342, 12'h343, 12'h3A0,
    12'h3B0, 12'h3B1, 12'h3B2, 12'h3B3, 12'h305
  };
  logic [2:0] csrFunct3 [6] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};

  `include "csrModel.svh"

  csrUnit i_csrUnit (
    .clk     (clk),
    .rstN    (rstN),
    .valid   (valid),
    .instr   (instr),
    .rs1Val  (rs1Val),
    .pc      (pc),
    .irqExt  (irqExt),
    .result  (result),
    .pmpCfg0 (pmpCfg0),
    .pmpAddr (pmpAddr)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic checkResult(input csrResultT got, input csrResultT exp);
    if (got.valid !== exp.valid || got.rdWe !== exp.rdWe || got.redirect !== exp.redirect) begin
      $display("ERR %0t valid/rdWe/redirect got %b%b%b expected %b%b%b", $time,
               got.valid, got.rdWe, got.redirect, exp.valid, exp.rdWe, exp.redirect);
      $display("Result: FAILED");
      $fatal(1, "result flags mismatch");
    end
    if (exp.rdWe && (got.rd !== exp.rd || got.rdVal !== exp.rdVal)) begin
      $display("ERR %0t rd x%0d = %h expected x%0d = %h", $time,
               got.rd, got.rdVal, exp.rd, exp.rdVal);
      $display("Result: FAILED");
      $fatal(1, "rd value mismatch");
    end
    if (exp.redirect && got.targetPc !== exp.targetPc) begin
      $display("ERR %0t targetPc %h expected %h", $time, got.targetPc, exp.targetPc);
      $display("Result: FAILED");
      $fatal(1, "target mismatch");
    end
  endtask

  task automatic checkPmp(input logic [31:0] cfg, input logic [3:0][31:0] adr);
    if (cfg !== pmpCfgReg || adr !== pmpAddrReg) begin
      $display("ERR %0t pmp cfg %h addr %h expected cfg %h addr %h", $time,
               cfg, adr, pmpCfgReg, pmpAddrReg);
      $display("Result: FAILED");
      $fatal(1, "pmp mismatch");
    end
  endtask

  // Check the previous strobe, then drive the next one
  task automatic applyCycle(input logic v, input logic [31:0] ins, input logic [31:0] r1,
                            input logic [31:0] p, input logic irq);
    @(negedge clk);
    checkResult(result, expResult);
    checkPmp(pmpCfg0, pmpAddr);
    valid  = v;
    instr  = ins;
    rs1Val = r1;
    pc     = p;
    irqExt = irq;
    predictStep(v, ins, r1, p, irq, expResult);
  endtask

  task automatic randomCycle();
    int          kind;
    int          pick;
    int          sel;
    logic [11:0] adr;
    logic [4:0]  rs1f;
    logic [4:0]  rd;
    logic [31:0] ins;
    logic        v;
    logic        irq;
    kind = $unsigned($random(seed)) % 16;
    pick = $unsigned($random(seed)) % 24;
    sel  = $unsigned($random(seed)) % 6;
    rd   = 5'($random(seed));
    rs1f = (($random(seed) & 3) == 0) ? 5'd0 : 5'($random(seed));
    irq  = (($random(seed) & 3) == 0);
    v    = 1'b1;
    // Extra weight on mstatus and mie so interrupts get enabled
    if (pick < numSweep) begin
      adr = adrTable[pick];
    end else if (pick < 21) begin
      adr = 12'h300;
    end else if (pick < 23) begin
      adr = 12'h304;
    end else begin
      adr = 12'($random(seed));
    end
    case (kind)
      9:  ins = 32'h0000_0073;
      10: ins = 32'h0010_0073;
      11: ins = 32'h3020_0073;
      12: ins = ($random(seed) & 32'hFFFF_8F80) | 32'h0000_4073;
      13: ins = ($random(seed) & 32'hFFF0_0F80) | 32'h0000_0073;
      14: ins = ($random(seed) & 32'hFFFF_FF80) | 32'h0000_0033;
      15: begin
        v   = 1'b0;
        ins = $random(seed);
      end
      default: ins = {adr, rs1f, csrFunct3[sel], rd, 7'h73};
    endcase
    applyCycle(v, ins, $random(seed), $random(seed) & 32'hFFFF_FFFC, irq);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk    = 1'b0;
    rstN   = 1'b0;
    valid  = 1'b0;
    instr  = '0;
    rs1Val = '0;
    pc     = '0;
    irqExt = 1'b0;
    resetModel();
    expResult = '0;
    repeat (8) @(negedge clk);
    rstN = 1'b1;
    // Read every CSR with CSRRS x0 from its reset value
    for (int i = 0; i < numSweep; i++) begin
      applyCycle(1'b1, {adrTable[i], 5'd0, 3'b010, 5'(i + 1), 7'h73}, $random(seed),
                 $random(seed) & 32'hFFFF_FFFC, $random(seed) & 1);
    end
    for (int i = 0; i < numRandom; i++) begin
      randomCycle();
    end
    @(negedge clk);
    checkResult(result, expResult);
    checkPmp(pmpCfg0, pmpAddr);
    $display("Result: PASSED");
    $finish;
  end

endmodule
